//--- src/riscv_pkg.sv
package riscv_pkg;

  localparam int XLEN = 64;

  // alu operation codes
  localparam logic [5:0] ALU_ADD   = 6'd0;
  localparam logic [5:0] ALU_SUB   = 6'd1;
  localparam logic [5:0] ALU_SLL   = 6'd2;
  localparam logic [5:0] ALU_SLT   = 6'd3;
  localparam logic [5:0] ALU_SLTU  = 6'd4;
  localparam logic [5:0] ALU_XOR   = 6'd5;
  localparam logic [5:0] ALU_SRL   = 6'd6;
  localparam logic [5:0] ALU_SRA   = 6'd7;
  localparam logic [5:0] ALU_OR    = 6'd8;
  localparam logic [5:0] ALU_AND   = 6'd9;
  localparam logic [5:0] ALU_ADDW  = 6'd10;
  localparam logic [5:0] ALU_SUBW  = 6'd11;
  localparam logic [5:0] ALU_PASSB = 6'd12; // lui

  localparam logic [1:0] FUNC_ALU = 2'd0;
  localparam logic [1:0] FUNC_MUL = 2'd1;

  // bit 3 enables, low bits are funct3
  localparam logic [3:0] BR_EQ  = 4'b1000;
  localparam logic [3:0] BR_NE  = 4'b1001;
  localparam logic [3:0] BR_LT  = 4'b1100;
  localparam logic [3:0] BR_GE  = 4'b1101;
  localparam logic [3:0] BR_LTU = 4'b1110;
  localparam logic [3:0] BR_GEU = 4'b1111;

  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;

  localparam logic [2:0] LD_B  = 3'd0;
  localparam logic [2:0] LD_H  = 3'd1;
  localparam logic [2:0] LD_W  = 3'd2;
  localparam logic [2:0] LD_D  = 3'd3;
  localparam logic [2:0] LD_BU = 3'd4;
  localparam logic [2:0] LD_HU = 3'd5;
  localparam logic [2:0] LD_WU = 3'd6;

  localparam logic [1:0] ST_B = 2'd0;
  localparam logic [1:0] ST_H = 2'd1;
  localparam logic [1:0] ST_W = 2'd2;
  localparam logic [1:0] ST_D = 2'd3;

  // peripheral map, each window is 4 KiB above its base
  localparam int          PERIPH_WIN_W = 12;
  localparam logic [63:0] TIMER_BASE   = 64'h0000_0000_0200_4000;
  localparam logic [63:0] UART_BASE    = 64'h0000_0000_0200_5000;
  localparam logic [63:0] SEG_BASE     = 64'h0000_0000_0200_6000;
  localparam logic [63:0] LED_BASE     = 64'h0000_0000_0200_7000;

  localparam logic [2:0] MSEL_DCACHE = 3'd0;
  localparam logic [2:0] MSEL_TIMER  = 3'd1;
  localparam logic [2:0] MSEL_UART   = 3'd2;
  localparam logic [2:0] MSEL_SEG    = 3'd3;
  localparam logic [2:0] MSEL_LED    = 3'd4;

  localparam int MUL_CYCLES = 64;
  localparam int MUL_CNT_W  = $clog2(MUL_CYCLES + 1);

endpackage

//--- src/riscv_alu.sv
`timescale 1ns/1ps

module riscv_alu import riscv_pkg::*; (
  input  logic [XLEN-1:0] i_a,
  input  logic [XLEN-1:0] i_b,
  input  logic [5:0]      i_op,
  output logic [XLEN-1:0] o_result
);

  logic [5:0]  shamt;
  logic [31:0] sum_w;
  logic [31:0] diff_w;

  assign shamt  = i_b[5:0];
  assign sum_w  = i_a[31:0] + i_b[31:0];
  assign diff_w = i_a[31:0] - i_b[31:0];

  always_comb begin
    case (i_op)
      ALU_ADD: begin
        o_result = i_a + i_b;
      end
      ALU_SUB: begin
        o_result = i_a - i_b;
      end
      ALU_SLL: begin
        o_result = i_a << shamt;
      end
      ALU_SLT: begin
        o_result = {{(XLEN-1){1'b0}}, $signed(i_a) < $signed(i_b)};
      end
      ALU_SLTU: begin
        o_result = {{(XLEN-1){1'b0}}, i_a < i_b};
      end
      ALU_XOR: begin
        o_result = i_a ^ i_b;
      end
      ALU_SRL: begin
        o_result = i_a >> shamt;
      end
      ALU_SRA: begin
        o_result = $signed(i_a) >>> shamt; // arithmetic, keeps sign
      end
      ALU_OR: begin
        o_result = i_a | i_b;
      end
      ALU_AND: begin
        o_result = i_a & i_b;
      end
      ALU_ADDW: begin
        o_result = {{(XLEN-32){sum_w[31]}}, sum_w};
      end
      ALU_SUBW: begin
        o_result = {{(XLEN-32){diff_w[31]}}, diff_w};
      end
      ALU_PASSB: begin
        o_result = i_b;
      end
      default: begin
        o_result = '0;
      end
    endcase
  end

endmodule

//--- src/riscv_mul.sv
`timescale 1ns/1ps

module riscv_mul import riscv_pkg::*; (
  input  logic            i_clk,
  input  logic            i_rst,
  input  logic            i_start,
  input  logic [XLEN-1:0] i_a,
  input  logic [XLEN-1:0] i_b,
  output logic            o_busy,
  output logic            o_done,
  output logic [XLEN-1:0] o_product
);

  logic [XLEN-1:0]      mcand;
  logic [XLEN-1:0]      mplier;
  logic [XLEN-1:0]      acc;
  logic [MUL_CNT_W-1:0] count;
  logic                 last;
  logic                 launch;

  assign last      = (count == MUL_CNT_W'(MUL_CYCLES));
  assign launch    = !o_busy && !o_done && i_start;
  assign o_product = acc;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_busy <= 1'b0;
      o_done <= 1'b0;
      count  <= '0;
    end else if (o_busy) begin
      if (last) begin
        o_busy <= 1'b0;
        o_done <= 1'b1;
      end else begin
        count <= count + 1'b1;
      end
    end else if (o_done) begin
      o_done <= i_start; // held while the stage is stalled
    end else if (i_start) begin
      o_busy <= 1'b1;
      count  <= '0;
    end
  end

  // one multiplier bit per cycle, lsb first
  always_ff @(posedge i_clk) begin
    if (launch) begin
      mcand  <= i_a;
      mplier <= i_b;
      acc    <= '0;
    end else if (o_busy && !last) begin
      if (mplier[0]) begin
        acc <= acc + mcand;
      end
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  a_busy_done_excl: assert property (@(posedge i_clk) disable iff (i_rst)
    !(o_busy && o_done));

  a_done_holds: assert property (@(posedge i_clk) disable iff (i_rst)
    $fell(o_done) |-> ($past(i_start) == 1'b0));

endmodule

//--- src/riscv_icu.sv
`timescale 1ns/1ps

module riscv_icu import riscv_pkg::*; (
  input  logic            i_clk,
  input  logic            i_rst,
  input  logic [XLEN-1:0] i_rs1data,
  input  logic [XLEN-1:0] i_rs2data,
  input  logic [XLEN-1:0] i_alurs1data,
  input  logic [XLEN-1:0] i_alurs2data,
  input  logic [3:0]      i_bcond,
  input  logic [3:0]      i_mulctrl,
  input  logic [5:0]      i_aluctrl,
  input  logic [1:0]      i_funcsel,
  output logic            o_branch_taken,
  output logic            o_valid,
  output logic [XLEN-1:0] o_result
);

  logic [XLEN-1:0] alu_result;
  logic [XLEN-1:0] mul_product;
  logic            mul_start;
  logic            mul_busy;
  logic            mul_done;
  logic            eq;
  logic            lt;
  logic            ltu;

  assign mul_start = (i_funcsel == FUNC_MUL) && i_mulctrl[3];

  riscv_alu u_alu (
    .i_a      (i_alurs1data),
    .i_b      (i_alurs2data),
    .i_op     (i_aluctrl),
    .o_result (alu_result)
  );

  riscv_mul u_mul (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_start   (mul_start),
    .i_a       (i_rs1data),
    .i_b       (i_rs2data),
    .o_busy    (mul_busy),
    .o_done    (mul_done),
    .o_product (mul_product)
  );

  // branch comparator on forwarded registers
  assign eq  = (i_rs1data == i_rs2data);
  assign lt  = ($signed(i_rs1data) < $signed(i_rs2data));
  assign ltu = (i_rs1data < i_rs2data);

  always_comb begin
    case (i_bcond)
      BR_EQ:   o_branch_taken = eq;
      BR_NE:   o_branch_taken = !eq;
      BR_LT:   o_branch_taken = lt;
      BR_GE:   o_branch_taken = !lt;
      BR_LTU:  o_branch_taken = ltu;
      BR_GEU:  o_branch_taken = !ltu;
      default: o_branch_taken = 1'b0; // includes enable low
    endcase
  end

  always_comb begin
    if (i_funcsel == FUNC_MUL) begin
      o_result = mul_product;
      o_valid  = mul_done;
    end else begin
      o_result = alu_result;
      o_valid  = !mul_busy; // a multiply still in flight blocks it
    end
  end

  a_no_branch_disabled: assert property (@(posedge i_clk) disable iff (i_rst)
    !i_bcond[3] |-> !o_branch_taken);

endmodule

//--- src/riscv_lsu.sv
`timescale 1ns/1ps

module riscv_lsu import riscv_pkg::*; (
  input  logic            i_globstall,
  input  logic [XLEN-1:0] i_address,
  input  logic            i_dcache_wren,
  input  logic            i_dcache_rden,
  input  logic            i_goto_trap,
  input  logic [1:0]      i_return_trap,
  output logic            o_dcache_wren,
  output logic            o_dcache_rden,
  output logic [XLEN-1:0] o_phy_address,
  output logic            o_timer_wren,
  output logic            o_timer_rden,
  output logic [1:0]      o_timer_regsel,
  output logic            o_uart_tx_valid,
  output logic            o_seg_en,
  output logic            o_led_en,
  output logic [2:0]      o_mstage_mux_sel
);

  logic [XLEN-PERIPH_WIN_W-1:0] page;
  logic                         timer_hit;
  logic                         uart_hit;
  logic                         seg_hit;
  logic                         led_hit;
  logic                         periph_hit;
  logic                         kill;
  logic                         side_ok;

  assign page       = i_address[XLEN-1:PERIPH_WIN_W];
  assign timer_hit  = (page == TIMER_BASE[XLEN-1:PERIPH_WIN_W]);
  assign uart_hit   = (page == UART_BASE[XLEN-1:PERIPH_WIN_W]);
  assign seg_hit    = (page == SEG_BASE[XLEN-1:PERIPH_WIN_W]);
  assign led_hit    = (page == LED_BASE[XLEN-1:PERIPH_WIN_W]);
  assign periph_hit = timer_hit || uart_hit || seg_hit || led_hit;

  assign kill    = i_goto_trap || (|i_return_trap);
  assign side_ok = !kill && !i_globstall; // stalled store must not repeat

  assign o_dcache_wren   = i_dcache_wren && !periph_hit && !kill;
  assign o_dcache_rden   = i_dcache_rden && !periph_hit && !kill;
  assign o_phy_address   = i_address;
  assign o_timer_wren    = i_dcache_wren && timer_hit && side_ok;
  assign o_timer_rden    = i_dcache_rden && timer_hit && !kill;
  assign o_timer_regsel  = i_address[4:3];
  assign o_uart_tx_valid = i_dcache_wren && uart_hit && side_ok;
  assign o_seg_en        = i_dcache_wren && seg_hit && side_ok;
  assign o_led_en        = i_dcache_wren && led_hit && side_ok;

  always_comb begin
    if (timer_hit) begin
      o_mstage_mux_sel = MSEL_TIMER;
    end else if (uart_hit) begin
      o_mstage_mux_sel = MSEL_UART;
    end else if (seg_hit) begin
      o_mstage_mux_sel = MSEL_SEG;
    end else if (led_hit) begin
      o_mstage_mux_sel = MSEL_LED;
    end else begin
      o_mstage_mux_sel = MSEL_DCACHE;
    end
  end

  always_comb begin
    a_one_write: assert ($onehot0({o_dcache_wren, o_timer_wren, o_uart_tx_valid,
                                   o_seg_en, o_led_en}))
      else $error("lsu: more than one write strobe");
  end

endmodule

//--- src/riscv_misalignment_unit.sv
`timescale 1ns/1ps

module riscv_misalignment_unit import riscv_pkg::*; (
  input  logic [6:0]      i_opcode,
  input  logic [XLEN-1:0] i_icu_result,
  input  logic            i_branch_taken,
  input  logic [2:0]      i_load_sel,
  input  logic [1:0]      i_store_sel,
  input  logic            i_memr,
  input  logic            i_memw,
  output logic            o_store_addr_misaligned,
  output logic            o_load_addr_misaligned,
  output logic            o_inst_addr_misaligned
);

  logic [2:0] offs;
  logic       is_jump;
  logic       ld_bad;
  logic       st_bad;

  assign offs    = i_icu_result[2:0];
  assign is_jump = (i_opcode == OP_JAL) || (i_opcode == OP_JALR) ||
                   ((i_opcode == OP_BRANCH) && i_branch_taken);

  always_comb begin
    case (i_load_sel)
      LD_H, LD_HU: ld_bad = offs[0];
      LD_W, LD_WU: ld_bad = |offs[1:0];
      LD_D:        ld_bad = |offs;
      default:     ld_bad = 1'b0; // bytes never misalign
    endcase
    case (i_store_sel)
      ST_B:    st_bad = 1'b0;
      ST_H:    st_bad = offs[0];
      ST_W:    st_bad = |offs[1:0];
      default: st_bad = |offs;
    endcase
  end

  assign o_inst_addr_misaligned  = is_jump && (|offs[1:0]); // no rvc, 4-byte targets
  assign o_load_addr_misaligned  = i_memr && ld_bad;
  assign o_store_addr_misaligned = i_memw && st_bad;

endmodule

//--- src/riscv_estage.sv
`timescale 1ns/1ps

module riscv_estage import riscv_pkg::*; (
  input  logic            i_riscv_estage_clk,
  input  logic            i_rst,
  input  logic            i_globstall,
  input  logic [1:0]      i_fwda,
  input  logic [1:0]      i_fwdb,
  input  logic            i_oprnd1sel,
  input  logic            i_oprnd2sel,
  input  logic [5:0]      i_aluctrl,
  input  logic [3:0]      i_mulctrl,
  input  logic [1:0]      i_funcsel,
  input  logic [3:0]      i_bcond,
  input  logic            i_imm_reg,
  input  logic [2:0]      i_memext,
  input  logic [6:0]      i_opcode,
  input  logic [1:0]      i_storesrc,
  input  logic            i_memw,
  input  logic            i_memr,
  input  logic            i_gtrap,
  input  logic [1:0]      i_rtrap,
  input  logic [XLEN-1:0] i_imm_m,
  input  logic [XLEN-1:0] i_rs1data,
  input  logic [XLEN-1:0] i_rs2data,
  input  logic [XLEN-1:0] i_rdata_wb,
  input  logic [XLEN-1:0] i_rddata_m,
  input  logic [XLEN-1:0] i_pc,
  input  logic [XLEN-1:0] i_simm,
  input  logic [XLEN-1:0] i_immextended,
  output logic [XLEN-1:0] o_result,
  output logic [XLEN-1:0] o_store_data,
  output logic            o_branchtaken,
  output logic            o_mul_en,
  output logic            o_icu_valid,
  output logic [XLEN-1:0] o_csrwritedata,
  output logic            o_inst_addr_misaligned,
  output logic            o_store_addr_misaligned,
  output logic            o_load_addr_misaligned,
  output logic            o_dcache_wren,
  output logic            o_dcache_rden,
  output logic [XLEN-1:0] o_dcache_addr,
  output logic            o_timer_wren,
  output logic            o_timer_rden,
  output logic [1:0]      o_timer_regsel,
  output logic            o_uart_tx_valid,
  output logic            o_seg_en,
  output logic            o_led_en,
  output logic [2:0]      o_mstage_mux_sel
);

  logic [XLEN-1:0] fwd_a;
  logic [XLEN-1:0] fwd_b;
  logic [XLEN-1:0] oprnd_a;
  logic [XLEN-1:0] oprnd_b;

  // forwarding selects
  always_comb begin
    case (i_fwda)
      2'd0:    fwd_a = i_rs1data;
      2'd1:    fwd_a = i_rdata_wb;
      2'd2:    fwd_a = i_rddata_m;
      default: fwd_a = i_imm_m;
    endcase
    case (i_fwdb)
      2'd0:    fwd_b = i_rs2data;
      2'd1:    fwd_b = i_rdata_wb;
      2'd2:    fwd_b = i_rddata_m;
      default: fwd_b = i_imm_m;
    endcase
  end

  assign oprnd_a        = i_oprnd1sel ? fwd_a : i_pc;
  assign oprnd_b        = i_oprnd2sel ? i_simm : fwd_b;
  assign o_csrwritedata = i_imm_reg ? i_immextended : fwd_a; // csr*i uses zimm
  assign o_store_data   = fwd_b;
  assign o_mul_en       = i_mulctrl[3];

  riscv_icu u_icu (
    .i_clk          (i_riscv_estage_clk),
    .i_rst          (i_rst),
    .i_rs1data      (fwd_a),
    .i_rs2data      (fwd_b),
    .i_alurs1data   (oprnd_a),
    .i_alurs2data   (oprnd_b),
    .i_bcond        (i_bcond),
    .i_mulctrl      (i_mulctrl),
    .i_aluctrl      (i_aluctrl),
    .i_funcsel      (i_funcsel),
    .o_branch_taken (o_branchtaken),
    .o_valid        (o_icu_valid),
    .o_result       (o_result)
  );

  riscv_lsu u_riscv_lsu (
    .i_globstall      (i_globstall),
    .i_address        (o_result),
    .i_dcache_wren    (i_memw),
    .i_dcache_rden    (i_memr),
    .i_goto_trap      (i_gtrap),
    .i_return_trap    (i_rtrap),
    .o_dcache_wren    (o_dcache_wren),
    .o_dcache_rden    (o_dcache_rden),
    .o_phy_address    (o_dcache_addr),
    .o_timer_wren     (o_timer_wren),
    .o_timer_rden     (o_timer_rden),
    .o_timer_regsel   (o_timer_regsel),
    .o_uart_tx_valid  (o_uart_tx_valid),
    .o_seg_en         (o_seg_en),
    .o_led_en         (o_led_en),
    .o_mstage_mux_sel (o_mstage_mux_sel)
  );

  riscv_misalignment_unit u_riscv_misalignment_unit (
    .i_opcode                (i_opcode),
    .i_icu_result            (o_result),
    .i_branch_taken          (o_branchtaken),
    .i_load_sel              (i_memext),
    .i_store_sel             (i_storesrc),
    .i_memr                  (i_memr),
    .i_memw                  (i_memw),
    .o_store_addr_misaligned (o_store_addr_misaligned),
    .o_load_addr_misaligned  (o_load_addr_misaligned),
    .o_inst_addr_misaligned  (o_inst_addr_misaligned)
  );

endmodule

//--- tb/riscv_estage_tests.svh
function automatic logic [6:0] strobe_vec();
  return {o_dcache_wren, o_dcache_rden, o_timer_wren, o_timer_rden,
          o_uart_tx_valid, o_seg_en, o_led_en};
endfunction

function automatic logic [63:0] fwd_source(input logic [1:0] code, input logic [63:0] rs);
  case (code)
    2'd0:    return rs;
    2'd1:    return i_rdata_wb;
    2'd2:    return i_rddata_m;
    default: return i_imm_m;
  endcase
endfunction

function automatic logic [63:0] alu_model(input logic [5:0] op, input logic [63:0] a,
                                          input logic [63:0] b);
  logic [5:0]  sh;
  logic [63:0] sra_fill;
  logic [31:0] w;
  sh       = b[5:0];
  sra_fill = a[63] ? ~(~64'd0 >> sh) : 64'd0; // sign bits shifted in from the top
  case (op)
    ALU_ADD:  return a + b;
    ALU_SUB:  return a - b;
    ALU_SLL:  return a << sh;
    ALU_SLT:  return (a[63] != b[63]) ? 64'(a[63]) : 64'(a < b);
    ALU_SLTU: return 64'(a < b);
    ALU_XOR:  return a ^ b;
    ALU_SRL:  return a >> sh;
    ALU_SRA:  return (a >> sh) | sra_fill;
    ALU_OR:   return a | b;
    ALU_AND:  return a & b;
    ALU_ADDW: begin
      w = a[31:0] + b[31:0];
      return {{32{w[31]}}, w};
    end
    ALU_SUBW: begin
      w = a[31:0] - b[31:0];
      return {{32{w[31]}}, w};
    end
    ALU_PASSB: return b;
    default:   return 64'd0;
  endcase
endfunction

function automatic logic branch_model(input logic [3:0] cond, input logic [63:0] a,
                                      input logic [63:0] b);
  logic lt_s;
  lt_s = (a[63] != b[63]) ? a[63] : (a < b);
  if (!cond[3]) begin
    return 1'b0;
  end
  case (cond[2:0])
    3'b000:  return a == b;
    3'b001:  return a != b;
    3'b100:  return lt_s;
    3'b101:  return !lt_s;
    3'b110:  return a < b;
    3'b111:  return a >= b;
    default: return 1'b0;
  endcase
endfunction

function automatic logic [2:0] target_of(input logic [63:0] addr);
  if (addr[63:12] == TIMER_BASE[63:12]) begin
    return MSEL_TIMER;
  end
  if (addr[63:12] == UART_BASE[63:12]) begin
    return MSEL_UART;
  end
  if (addr[63:12] == SEG_BASE[63:12]) begin
    return MSEL_SEG;
  end
  if (addr[63:12] == LED_BASE[63:12]) begin
    return MSEL_LED;
  end
  return MSEL_DCACHE;
endfunction

function automatic logic [6:0] expected_strobes(input logic [2:0] tgt, input logic rd,
                                                input logic wr, input logic kill,
                                                input logic stall);
  logic side;
  side = !kill && !stall; // one-shot peripheral effects
  return {wr && (tgt == MSEL_DCACHE) && !kill,
          rd && (tgt == MSEL_DCACHE) && !kill,
          wr && (tgt == MSEL_TIMER) && side,
          rd && (tgt == MSEL_TIMER) && !kill,
          wr && (tgt == MSEL_UART) && side,
          wr && (tgt == MSEL_SEG) && side,
          wr && (tgt == MSEL_LED) && side};
endfunction

function automatic int load_bytes(input logic [2:0] sel);
  case (sel)
    LD_H, LD_HU: return 2;
    LD_W, LD_WU: return 4;
    LD_D:        return 8;
    default:     return 1;
  endcase
endfunction

task automatic reset_defaults();
  next_drive();
  clear_inputs();
  i_funcsel = FUNC_MUL; // multiplier idle, nothing done yet
  settle();
  check("o_icu_valid", 64'(o_icu_valid), 64'd0);
  check("strobes", 64'(strobe_vec()), 64'd0);
endtask

task automatic forwarding_paths();
  logic [63:0] exp_a;
  logic [63:0] exp_b;
  for (int k = 0; k < 4; k++) begin
    next_drive();
    clear_inputs();
    i_rs1data     = rand64();
    i_rs2data     = rand64();
    i_rdata_wb    = rand64();
    i_rddata_m    = rand64();
    i_imm_m       = rand64();
    i_immextended = rand64();
    i_fwda        = 2'(k);
    i_fwdb        = 2'(3 - k);
    i_oprnd1sel   = 1'b1;
    i_oprnd2sel   = 1'b1; // simm is zero so the sum is operand a
    exp_a = fwd_source(i_fwda, i_rs1data);
    exp_b = fwd_source(i_fwdb, i_rs2data);
    settle();
    check("o_result", o_result, exp_a);
    check("o_store_data", o_store_data, exp_b);
    check("o_csrwritedata", o_csrwritedata, exp_a);
    next_drive();
    i_aluctrl   = ALU_PASSB;
    i_oprnd2sel = 1'b0;
    i_imm_reg   = 1'b1;
    settle();
    check("o_result", o_result, exp_b);
    check("o_csrwritedata", o_csrwritedata, i_immextended);
  end
  next_drive();
  clear_inputs();
  i_pc        = rand64();
  i_simm      = rand64();
  i_oprnd2sel = 1'b1; // pc plus immediate
  settle();
  check("o_result", o_result, i_pc + i_simm);
endtask

task automatic alu_ops();
  logic [63:0] a_val [6];
  logic [63:0] b_val [6];
  a_val = '{rand64(), rand64(), 64'h8000_0000_0000_0001, 64'hffff_ffff_ffff_fff0,
            64'h0000_0000_7fff_ffff, 64'h0000_0000_8000_0000};
  b_val = '{rand64(), rand64(), 64'd63, 64'd64, 64'd1, 64'hffff_ffff_ffff_ffff};
  for (int p = 0; p < 6; p++) begin
    for (int op = 0; op <= 13; op++) begin // 13 is unlisted
      next_drive();
      clear_inputs();
      i_rs1data   = a_val[p];
      i_rs2data   = b_val[p];
      i_oprnd1sel = 1'b1;
      i_aluctrl   = 6'(op);
      settle();
      check($sformatf("o_result op %0d", op), o_result, alu_model(6'(op), a_val[p], b_val[p]));
    end
  end
endtask

task automatic branch_conditions();
  logic [63:0] a_val [5];
  logic [63:0] b_val [5];
  logic [3:0]  conds [8];
  a_val = '{64'd5, 64'd3, 64'd9, 64'hffff_ffff_ffff_fffd, 64'hffff_ffff_ffff_fff8};
  b_val = '{64'd5, 64'd9, 64'd3, 64'd4, 64'hffff_ffff_ffff_fffe};
  conds = '{BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, 4'b0000, 4'b0101};
  for (int p = 0; p < 5; p++) begin
    for (int c = 0; c < 8; c++) begin
      next_drive();
      clear_inputs();
      i_rs1data = a_val[p];
      i_rs2data = b_val[p];
      i_bcond   = conds[c];
      settle();
      check($sformatf("o_branchtaken bcond %h", conds[c]), 64'(o_branchtaken),
            64'(branch_model(conds[c], a_val[p], b_val[p])));
    end
  end
endtask

task automatic run_multiply(input logic [63:0] a, input logic [63:0] b, input int hold);
  int          edges;
  logic [63:0] prod;
  prod = $signed(a) * $signed(b); // low half, same for either sign
  next_drive();
  clear_inputs();
  i_rs1data = a;
  i_rs2data = b;
  i_funcsel = FUNC_MUL;
  i_mulctrl = 4'b1000;
  settle();
  check("o_mul_en", 64'(o_mul_en), 64'd1);
  check("o_icu_valid", 64'(o_icu_valid), 64'd0);
  @(posedge clk); // start edge
  edges = 0;
  #30;
  while (!o_icu_valid && edges < MUL_CYCLES + 8) begin
    @(posedge clk);
    edges++;
    #30;
  end
  if (!o_icu_valid) begin
    errors++;
    $display("multiply did not raise o_icu_valid within %0d cycles", edges);
  end
  check("mul latency", 64'(edges), 64'(MUL_CYCLES + 1));
  check("o_result", o_result, prod);
  repeat (hold) begin
    @(posedge clk);
    #30;
    check("o_icu_valid", 64'(o_icu_valid), 64'd1);
    check("o_result", o_result, prod);
  end
  next_drive();
  i_mulctrl = 4'b0000; // release, done clears on the next edge
  next_drive();
  settle();
  check("o_icu_valid", 64'(o_icu_valid), 64'd0);
  check("o_mul_en", 64'(o_mul_en), 64'd0);
endtask

task automatic multiply_sequence();
  run_multiply(rand64(), rand64(), 3);
  run_multiply(64'hffff_ffff_ffff_fff9, 64'd123456789, 1);
  run_multiply(64'hffff_ffff_ffff_ffff, 64'h8000_0000_0000_0003, 0);
  next_drive();
  clear_inputs();
  settle();
  check("o_icu_valid", 64'(o_icu_valid), 64'd1);
endtask

task automatic address_decode();
  logic [63:0] addrs [7];
  logic [2:0]  tgt;
  addrs = '{TIMER_BASE + 64'h18, UART_BASE + 64'h8, SEG_BASE + 64'hff8, LED_BASE + 64'h10,
            64'h0000_0000_8000_1000, TIMER_BASE - 64'h8, LED_BASE + 64'h1000};
  for (int n = 0; n < 7; n++) begin
    for (int mode = 0; mode < 4; mode++) begin // none, gtrap, rtrap, stall
      for (int rw = 0; rw < 2; rw++) begin
        next_drive();
        clear_inputs();
        i_rs1data   = addrs[n] - 64'h10;
        i_simm      = 64'h10;
        i_oprnd1sel = 1'b1;
        i_oprnd2sel = 1'b1;
        i_memr      = (rw == 0);
        i_memw      = (rw == 1);
        i_gtrap     = (mode == 1);
        i_rtrap     = (mode == 2) ? 2'b10 : 2'b00;
        i_globstall = (mode == 3);
        tgt = target_of(addrs[n]);
        settle();
        check("o_dcache_addr", o_dcache_addr, addrs[n]);
        check("o_mstage_mux_sel", 64'(o_mstage_mux_sel), 64'(tgt));
        check("o_timer_regsel", 64'(o_timer_regsel), 64'(addrs[n][4:3]));
        check("strobes", 64'(strobe_vec()),
              64'(expected_strobes(tgt, i_memr, i_memw, (mode == 1) || (mode == 2), mode == 3)));
      end
    end
  end
endtask

task automatic jump_case(input logic [6:0] op, input logic [3:0] cond, input logic [63:0] off);
  logic bad;
  next_drive();
  clear_inputs();
  i_opcode    = op;
  i_bcond     = cond;
  i_pc        = 64'h0000_0000_0000_2000;
  i_simm      = off;
  i_oprnd2sel = 1'b1;
  i_rs1data   = 64'h55;
  i_rs2data   = 64'h55;
  bad = ((op == OP_JAL) || (op == OP_JALR) ||
         ((op == OP_BRANCH) && branch_model(cond, 64'h55, 64'h55))) && (off[1:0] != 2'b00);
  settle();
  check("o_inst_addr_misaligned", 64'(o_inst_addr_misaligned), 64'(bad));
endtask

task automatic misalignment_flags();
  logic [2:0] lds [7];
  int         size;
  lds = '{LD_B, LD_H, LD_W, LD_D, LD_BU, LD_HU, LD_WU};
  for (int s = 0; s < 11; s++) begin // seven loads, then four stores
    for (int off = 0; off < 8; off++) begin
      next_drive();
      clear_inputs();
      i_pc        = 64'h0000_0000_0000_1000;
      i_simm      = 64'(off);
      i_oprnd2sel = 1'b1;
      if (s < 7) begin
        i_memr   = 1'b1;
        i_memext = lds[s];
        i_opcode = 7'b0000011;
        size = load_bytes(lds[s]);
      end else begin
        i_memw     = 1'b1;
        i_storesrc = 2'(s - 7);
        i_opcode   = 7'b0100011;
        size = 1 << (s - 7);
      end
      settle();
      check("o_load_addr_misaligned", 64'(o_load_addr_misaligned),
            64'(s < 7 && (off % size) != 0));
      check("o_store_addr_misaligned", 64'(o_store_addr_misaligned),
            64'(s >= 7 && (off % size) != 0));
      check("o_inst_addr_misaligned", 64'(o_inst_addr_misaligned), 64'd0);
    end
  end
  jump_case(OP_JAL, 4'b0000, 64'd2);
  jump_case(OP_JAL, 4'b0000, 64'd4);
  jump_case(OP_JALR, 4'b0000, 64'd2);
  jump_case(OP_BRANCH, BR_EQ, 64'd2);
  jump_case(OP_BRANCH, BR_NE, 64'd2); // not taken
  jump_case(OP_BRANCH, BR_EQ, 64'd8);
endtask

//--- tb/tb_riscv_estage.sv
`timescale 1ns/1ps

module tb_riscv_estage import riscv_pkg::*; ();

  localparam int PERIOD      = 40;
  localparam int CYCLE_LIMIT = 6 * (MUL_CYCLES + 10) + 400; // three multiplies plus directed checks

  logic        clk;
  logic        rst;
  logic        i_globstall;
  logic [1:0]  i_fwda;
  logic [1:0]  i_fwdb;
  logic        i_oprnd1sel;
  logic        i_oprnd2sel;
  logic [5:0]  i_aluctrl;
  logic [3:0]  i_mulctrl;
  logic [1:0]  i_funcsel;
  logic [3:0]  i_bcond;
  logic        i_imm_reg;
  logic [2:0]  i_memext;
  logic [6:0]  i_opcode;
  logic [1:0]  i_storesrc;
  logic        i_memw;
  logic        i_memr;
  logic        i_gtrap;
  logic [1:0]  i_rtrap;
  logic [63:0] i_imm_m;
  logic [63:0] i_rs1data;
  logic [63:0] i_rs2data;
  logic [63:0] i_rdata_wb;
  logic [63:0] i_rddata_m;
  logic [63:0] i_pc;
  logic [63:0] i_simm;
  logic [63:0] i_immextended;

  logic [63:0] o_result;
  logic [63:0] o_store_data;
  logic        o_branchtaken;
  logic        o_mul_en;
  logic        o_icu_valid;
  logic [63:0] o_csrwritedata;
  logic        o_inst_addr_misaligned;
  logic        o_store_addr_misaligned;
  logic        o_load_addr_misaligned;
  logic        o_dcache_wren;
  logic        o_dcache_rden;
  logic [63:0] o_dcache_addr;
  logic        o_timer_wren;
  logic        o_timer_rden;
  logic [1:0]  o_timer_regsel;
  logic        o_uart_tx_valid;
  logic        o_seg_en;
  logic        o_led_en;
  logic [2:0]  o_mstage_mux_sel;

  int          errors = 0;
  int          checks = 0;
  int          cycles;
  logic [31:0] lcg_state = 32'hf831_298e;

  riscv_estage i_riscv_estage (
    .i_riscv_estage_clk      (clk),
    .i_rst                   (rst),
    .i_globstall             (i_globstall),
    .i_fwda                  (i_fwda),
    .i_fwdb                  (i_fwdb),
    .i_oprnd1sel             (i_oprnd1sel),
    .i_oprnd2sel             (i_oprnd2sel),
    .i_aluctrl               (i_aluctrl),
    .i_mulctrl               (i_mulctrl),
    .i_funcsel               (i_funcsel),
    .i_bcond                 (i_bcond),
    .i_imm_reg               (i_imm_reg),
    .i_memext                (i_memext),
    .i_opcode                (i_opcode),
    .i_storesrc              (i_storesrc),
    .i_memw                  (i_memw),
    .i_memr                  (i_memr),
    .i_gtrap                 (i_gtrap),
    .i_rtrap                 (i_rtrap),
    .i_imm_m                 (i_imm_m),
    .i_rs1data               (i_rs1data),
    .i_rs2data               (i_rs2data),
    .i_rdata_wb              (i_rdata_wb),
    .i_rddata_m              (i_rddata_m),
    .i_pc                    (i_pc),
    .i_simm                  (i_simm),
    .i_immextended           (i_immextended),
    .o_result                (o_result),
    .o_store_data            (o_store_data),
    .o_branchtaken           (o_branchtaken),
    .o_mul_en                (o_mul_en),
    .o_icu_valid             (o_icu_valid),
    .o_csrwritedata          (o_csrwritedata),
    .o_inst_addr_misaligned  (o_inst_addr_misaligned),
    .o_store_addr_misaligned (o_store_addr_misaligned),
    .o_load_addr_misaligned  (o_load_addr_misaligned),
    .o_dcache_wren           (o_dcache_wren),
    .o_dcache_rden           (o_dcache_rden),
    .o_dcache_addr           (o_dcache_addr),
    .o_timer_wren            (o_timer_wren),
    .o_timer_rden            (o_timer_rden),
    .o_timer_regsel          (o_timer_regsel),
    .o_uart_tx_valid         (o_uart_tx_valid),
    .o_seg_en                (o_seg_en),
    .o_led_en                (o_led_en),
    .o_mstage_mux_sel        (o_mstage_mux_sel)
  );

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [63:0] rand64();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = lcg_next();
    lo = lcg_next();
    return {hi, lo};
  endfunction

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %s: got 0x%016h expected 0x%016h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic next_drive();
    @(posedge clk);
    #2; // inputs change just after the edge
  endtask

  task automatic settle();
    #30; // sample point, 8 ns before the next edge
  endtask

  task automatic clear_inputs();
    i_globstall   = 1'b0;
    i_fwda        = 2'd0;
    i_fwdb        = 2'd0;
    i_oprnd1sel   = 1'b0;
    i_oprnd2sel   = 1'b0;
    i_aluctrl     = ALU_ADD;
    i_mulctrl     = 4'b0000;
    i_funcsel     = FUNC_ALU;
    i_bcond       = 4'b0000;
    i_imm_reg     = 1'b0;
    i_memext      = LD_B;
    i_opcode      = 7'b0110011; // plain register op
    i_storesrc    = ST_B;
    i_memw        = 1'b0;
    i_memr        = 1'b0;
    i_gtrap       = 1'b0;
    i_rtrap       = 2'b00;
    i_imm_m       = 64'd0;
    i_rs1data     = 64'd0;
    i_rs2data     = 64'd0;
    i_rdata_wb    = 64'd0;
    i_rddata_m    = 64'd0;
    i_pc          = 64'd0;
    i_simm        = 64'd0;
    i_immextended = 64'd0;
  endtask

  `include "riscv_estage_tests.svh"

  initial begin
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: the run went past %0d clock cycles", CYCLE_LIMIT);
    $display("Some tests failed");
    $finish;
  end

  initial begin
    rst = 1'b1;
    clear_inputs();
    repeat (3) @(posedge clk);
    #2;
    rst = 1'b0;
    reset_defaults();
    forwarding_paths();
    alu_ops();
    branch_conditions();
    multiply_sequence();
    address_decode();
    misalignment_flags();
    $display("errors: %0d, checks: %0d", errors, checks);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- riscv_estage.f
+incdir+tb
src/riscv_pkg.sv
src/riscv_alu.sv
src/riscv_mul.sv
src/riscv_icu.sv
src/riscv_lsu.sv
src/riscv_misalignment_unit.sv
src/riscv_estage.sv
tb/tb_riscv_estage.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the execute stage testbench with verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_riscv_estage -f riscv_estage.f \
    -Mdir obj_dir -o tb_riscv_estage; then
  echo "verilator build failed"
  exit 1
fi

if ! ./obj_dir/tb_riscv_estage > sim.log 2>&1; then
  cat sim.log
  echo "simulation exited with an error"
  exit 1
fi

cat sim.log
if grep -q "Some tests failed" sim.log; then
  exit 1
fi
exit 0
